//--- compile.f
+incdir+hdl
hdl/stream_pkg.sv
hdl/interval_gate.sv
hdl/msg_queue.sv
hdl/delay_stream.sv
hdl/delay_cfg_regs.sv
hdl/delay_stream_top.sv
tests/delay_stream_tb.sv

//--- tests/delay_stream_tb.sv
//------------------------------------------------------------
// Delay stream testbench
// Drives both stream sides and the Wishbone port, checks
// order against a reference queue, the interval gaps,
// back-pressure and the register block
//------------------------------------------------------------

`timescale 1ns/1ns

`include "stream_consts.svh"

module delay_stream_tb;

  import stream_pkg::*;

  // Reset, reads, random burst, interval bursts, fill, registers, margin
  localparam int CYCLE_LIMIT = 40 + 50 * 8 + 12 * 4 + 12 * 3 + 60 + 20 * 4 + 500;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  wb_req_t     wb_req = '0;
  wb_rsp_t     wb_rsp;
  logic        send_val = 1'b0;
  logic        send_rdy;
  stream_msg_t send_msg = '0;
  logic        recv_val;
  logic        recv_rdy = 1'b0;
  stream_msg_t recv_msg;

  // Reference model and bookkeeping
  stream_msg_t ref_q[$];
  int          send_times[$];
  int          recv_times[$];
  int          cyc = 0;
  int          checks = 0;
  int          errors = 0;
  int          err_mark = 0;
  int          send_total = 0;
  int          recv_total = 0;
  int          acks = 0;
  int          wb_reqs = 0;
  int          recv_mode = 0;

  delay_stream_top u_delay_stream_top (
    .clk      (clk),
    .rst      (rst),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .send_msg (send_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .recv_msg (recv_msg)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  //----------------------------------------------------------
  // Checks and reference
  //----------------------------------------------------------

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      $display("error: %s", what);
      errors++;
    end
  endtask

  // Next accepted message in send order
  function automatic stream_msg_t expected_msg();
    return ref_q.pop_front();
  endfunction

  // Compare process samples before the edge updates
  always @(posedge clk) begin
    if (!rst) begin
      if (wb_rsp.ack) acks++;
      if (send_val && send_rdy) begin
        ref_q.push_back(send_msg);
        send_times.push_back(cyc);
        send_total++;
      end
      if (recv_val && recv_rdy) begin
        recv_times.push_back(cyc);
        recv_total++;
        check_true(ref_q.size() > 0, "recv transfer with no message outstanding");
        if (ref_q.size() > 0) check_val("recv_msg", recv_msg, expected_msg());
      end
    end
  end

  // Receive ready per mode 0 low, 1 high, else random
  always @(negedge clk) begin
    case (recv_mode)
      0:       recv_rdy = 1'b0;
      1:       recv_rdy = 1'b1;
      default: recv_rdy = 1'($urandom_range(0, 1));
    endcase
  end

  //----------------------------------------------------------
  // Drivers enter and leave on a falling edge
  //----------------------------------------------------------

  task automatic set_recv_mode(input int m);
    recv_mode <= m;
    @(negedge clk);
  endtask

  task automatic send_one(input stream_msg_t m);
    send_val = 1'b1;
    send_msg = m;
    do @(posedge clk); while (!send_rdy);
    @(negedge clk);
    send_val = 1'b0;
  endtask

  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdat};
    wb_reqs++;
    do @(posedge clk); while (!wb_rsp.ack);
    rdat = wb_rsp.dat_r;
    @(negedge clk);
    wb_req = '0;
  endtask

  task automatic reg_check(input logic [1:0] adr, input logic [31:0] exp, input string name);
    logic [31:0] rd;
    wb_access(1'b0, adr, 32'h0, rd);
    check_val(name, rd, exp);
  endtask

  task automatic wait_drain();
    while (ref_q.size() != 0) @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    $display("%s: done, %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  //----------------------------------------------------------
  // Test sequence
  //----------------------------------------------------------

  initial begin
    logic [31:0] rd;
    int          accepted;
    int          stall;
    bit          took;
    void'($urandom(32'he5bd));
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Output slot and ready still in reset state here
    check_val("send_rdy", send_rdy, 0);
    check_val("recv_val", recv_val, 0);
    reg_check(`REG_SEND_INTV, 0, "send_intv");
    reg_check(`REG_RECV_INTV, 0, "recv_intv");
    reg_check(`REG_SEND_CNT, 0, "send_cnt");
    reg_check(`REG_RECV_CNT, 0, "recv_cnt");
    finish_test("reset state");

    set_recv_mode(2);
    for (int i = 0; i < 50; i++) send_one('{tag: 8'(i), data: $urandom});
    wait_drain();
    set_recv_mode(1);
    check_val("recv total", recv_total, 50);
    finish_test("order and integrity");

    // Send interval 3 gives one accept every 4 cycles
    wb_access(1'b1, `REG_SEND_INTV, 32'd3, rd);
    send_times.delete();
    for (int i = 0; i < 6; i++) send_one('{tag: 8'h30 + 8'(i), data: $urandom});
    wait_drain();
    for (int i = 1; i < send_times.size(); i++)
      check_val("send gap", send_times[i] - send_times[i-1], 4);
    wb_access(1'b1, `REG_SEND_INTV, 32'd0, rd);

    // Receive interval 2 with a burst that keeps the queue busy
    wb_access(1'b1, `REG_RECV_INTV, 32'd2, rd);
    recv_times.delete();
    for (int i = 0; i < 6; i++) send_one('{tag: 8'h40 + 8'(i), data: $urandom});
    wait_drain();
    check_val("recv count", recv_times.size(), 6);
    for (int i = 1; i < recv_times.size(); i++)
      check_val("recv gap", recv_times[i] - recv_times[i-1], 3);
    wb_access(1'b1, `REG_RECV_INTV, 32'd0, rd);
    finish_test("intervals");

    // Fill with the output held off
    set_recv_mode(0);
    accepted = 0;
    stall = 0;
    send_val = 1'b1;
    send_msg = '{tag: 8'h50, data: $urandom};
    while (stall < 12) begin
      @(posedge clk);
      took = send_rdy;
      if (took) accepted++;
      stall = took ? 0 : stall + 1;
      @(negedge clk);
      if (took) send_msg = '{tag: 8'h50 + 8'(accepted), data: $urandom};
    end
    send_val = 1'b0;
    check_val("accepted", accepted, `QUEUE_DEPTH);
    set_recv_mode(1);
    wait_drain();
    finish_test("back-pressure");

    // Upper write bits dropped by the interval width
    wb_access(1'b1, `REG_SEND_INTV, 32'h1234_565a, rd);
    wb_access(1'b1, `REG_RECV_INTV, 32'hfedc_ba3c, rd);
    wb_access(1'b1, `REG_SEND_CNT, 32'hdead_beef, rd);
    wb_access(1'b1, `REG_RECV_CNT, 32'h0bad_cafe, rd);
    reg_check(`REG_SEND_INTV, 32'h5a, "send_intv");
    reg_check(`REG_RECV_INTV, 32'h3c, "recv_intv");
    reg_check(`REG_SEND_CNT, 32'(send_total), "send_cnt");
    reg_check(`REG_RECV_CNT, 32'(recv_total), "recv_cnt");
    @(negedge clk);
    check_val("ack count", acks, wb_reqs);
    finish_test("registers and counters");

    $display("summary: %0d checks, %0d passed, %0d failed", checks, checks - errors, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- hdl/delay_stream_top.sv
//------------------------------------------------------------
// Delay stream top level
// Delay stage with its Wishbone configuration block
//------------------------------------------------------------

`timescale 1ns/1ns

module delay_stream_top (
  input  logic                    clk,
  input  logic                    rst,

  // Register port
  input  stream_pkg::wb_req_t     wb_req,
  output stream_pkg::wb_rsp_t     wb_rsp,

  // Input stream
  input  logic                    send_val,
  output logic                    send_rdy,
  input  stream_pkg::stream_msg_t send_msg,

  // Output stream
  output logic                    recv_val,
  input  logic                    recv_rdy,
  output stream_pkg::stream_msg_t recv_msg
);

  import stream_pkg::*;

  delay_cfg_t cfg;
  logic       send_fire;
  logic       recv_fire;

  // Intervals and counters
  delay_cfg_regs u_cfg_regs (
    .clk       (clk),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .cfg       (cfg),
    .send_fire (send_fire),
    .recv_fire (recv_fire)
  );

  // Stream path
  delay_stream #(
    .t_msg (stream_msg_t)
  ) u_delay_stream (
    .clk       (clk),
    .rst       (rst),
    .cfg       (cfg),
    .send_val  (send_val),
    .send_rdy  (send_rdy),
    .send_msg  (send_msg),
    .recv_val  (recv_val),
    .recv_rdy  (recv_rdy),
    .recv_msg  (recv_msg),
    .send_fire (send_fire),
    .recv_fire (recv_fire)
  );

endmodule

//--- hdl/delay_cfg_regs.sv
//------------------------------------------------------------
// Delay configuration registers
// Wishbone classic slave with the two interval registers
// and free-running send and receive transfer counters
//------------------------------------------------------------

`timescale 1ns/1ns

`include "stream_consts.svh"

module delay_cfg_regs (
  input  logic                   clk,
  input  logic                   rst,
  input  stream_pkg::wb_req_t    wb_req,
  output stream_pkg::wb_rsp_t    wb_rsp,
  output stream_pkg::delay_cfg_t cfg,
  input  logic                   send_fire,
  input  logic                   recv_fire
);

  import stream_pkg::*;

  delay_cfg_t  cfg_q;
  logic [31:0] send_cnt;
  logic [31:0] recv_cnt;
  logic        ack_q;
  logic [31:0] rdata_q;
  logic [31:0] rdata;
  logic        req;

  // New request, the cycle after ack is skipped
  assign req = wb_req.cyc & wb_req.stb & !ack_q;

  assign cfg          = cfg_q;
  assign wb_rsp.ack   = ack_q;
  assign wb_rsp.dat_r = rdata_q;

  //----------------------------------------------------------
  // Read mux
  //----------------------------------------------------------

  always_comb begin
    unique case (wb_req.adr)
      `REG_SEND_INTV: rdata = 32'(cfg_q.send_intv);
      `REG_RECV_INTV: rdata = 32'(cfg_q.recv_intv);
      `REG_SEND_CNT:  rdata = send_cnt;
      `REG_RECV_CNT:  rdata = recv_cnt;
      default:        rdata = '0;
    endcase
  end

  // Read data sampled with the ack
  always_ff @(posedge clk) begin
    if (req) begin
      rdata_q <= rdata;
    end
  end

  //----------------------------------------------------------
  // Registers, ack and counters
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q    <= 1'b0;
      cfg_q    <= '0;
      send_cnt <= '0;
      recv_cnt <= '0;
    end else begin
      ack_q <= req;
      // Only the interval words are writable
      if (req && wb_req.we) begin
        if (wb_req.adr == `REG_SEND_INTV) begin
          cfg_q.send_intv <= wb_req.dat_w[`INTV_W-1:0];
        end
        if (wb_req.adr == `REG_RECV_INTV) begin
          cfg_q.recv_intv <= wb_req.dat_w[`INTV_W-1:0];
        end
      end
      // Wrapping transfer totals
      if (send_fire) begin
        send_cnt <= send_cnt + 1'b1;
      end
      if (recv_fire) begin
        recv_cnt <= recv_cnt + 1'b1;
      end
    end
  end

  // One request, one single-cycle ack
  a_ack_single: assert property (
    @(posedge clk) disable iff (rst)
    ack_q |=> !ack_q
  );

endmodule

//--- hdl/delay_stream.sv
//------------------------------------------------------------
// Delay stream stage
// Send gate, message queue and receive gate in a row
// Keeps run-time idle intervals between transfers on each
// side, the queue absorbs the rate difference
//------------------------------------------------------------

`timescale 1ns/1ns

module delay_stream #(
  parameter type t_msg = logic
) (
  input  logic                   clk,
  input  logic                   rst,
  input  stream_pkg::delay_cfg_t cfg,

  // Input stream
  input  logic                   send_val,
  output logic                   send_rdy,
  input  t_msg                   send_msg,

  // Output stream
  output logic                   recv_val,
  input  logic                   recv_rdy,
  output t_msg                   recv_msg,

  // Transfer strobes for the counters
  output logic                   send_fire,
  output logic                   recv_fire
);

  // Queue handshakes between the gates
  logic q_in_val;
  logic q_in_rdy;
  logic q_out_val;
  logic q_out_rdy;

  //----------------------------------------------------------
  // Send side
  //----------------------------------------------------------

  // Closes the input for send_intv cycles per accept
  interval_gate u_send_gate (
    .clk      (clk),
    .rst      (rst),
    .intv     (cfg.send_intv),
    .up_val   (send_val),
    .up_rdy   (send_rdy),
    .down_val (q_in_val),
    .down_rdy (q_in_rdy),
    .fire     (send_fire)
  );

  //----------------------------------------------------------
  // Queue, the only message path
  //----------------------------------------------------------

  msg_queue #(
    .t_msg (t_msg)
  ) u_queue (
    .clk     (clk),
    .rst     (rst),
    .in_val  (q_in_val),
    .in_rdy  (q_in_rdy),
    .in_msg  (send_msg),
    .out_val (q_out_val),
    .out_rdy (q_out_rdy),
    .out_msg (recv_msg)
  );

  //----------------------------------------------------------
  // Receive side
  //----------------------------------------------------------

  // Hides queue head for recv_intv cycles per delivery
  interval_gate u_recv_gate (
    .clk      (clk),
    .rst      (rst),
    .intv     (cfg.recv_intv),
    .up_val   (q_out_val),
    .up_rdy   (q_out_rdy),
    .down_val (recv_val),
    .down_rdy (recv_rdy),
    .fire     (recv_fire)
  );

endmodule

//--- hdl/msg_queue.sv
//------------------------------------------------------------
// Message queue
// Synchronous FIFO with valid/ready on both sides and a
// registered output slot, capacity DEPTH messages in all
//------------------------------------------------------------

`timescale 1ns/1ns

`include "stream_consts.svh"

module msg_queue #(
  parameter type t_msg = logic,
  parameter int  DEPTH = `QUEUE_DEPTH
) (
  input  logic clk,
  input  logic rst,
  input  logic in_val,
  output logic in_rdy,
  input  t_msg in_msg,
  output logic out_val,
  input  logic out_rdy,
  output t_msg out_msg
);

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] CAP = (AW+1)'(DEPTH);

  // Storage, no reset on payload
  t_msg mem [DEPTH];

  // Pointers carry one extra wrap bit
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] mem_count;
  logic [AW:0] occ;
  logic [AW:0] occ_next;
  logic        mem_empty;
  logic        push;
  logic        pop;
  logic        load;

  assign push = in_val & in_rdy;
  assign pop  = out_val & out_rdy;

  assign mem_count = wr_ptr - rd_ptr;
  assign mem_empty = (wr_ptr == rd_ptr);

  // Refill the output slot when free or being drained
  assign load = !mem_empty & (!out_val | out_rdy);

  // Total fill counts the output slot too
  assign occ      = mem_count + {{AW{1'b0}}, out_val};
  assign occ_next = occ + {{AW{1'b0}}, push} - {{AW{1'b0}}, pop};

  //----------------------------------------------------------
  // Data path
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= in_msg;
    end
    if (load) begin
      out_msg <= mem[rd_ptr[AW-1:0]];
    end
  end

  //----------------------------------------------------------
  // Control
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      out_val <= 1'b0;
      in_rdy  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (load) begin
        rd_ptr  <= rd_ptr + 1'b1;
        out_val <= 1'b1;
      end else if (pop) begin
        out_val <= 1'b0;
      end
      // Registered ready, low once the next fill reaches capacity
      in_rdy <= (occ_next != CAP);
    end
  end

  // Registered ready must agree with the fill level
  a_no_push_full: assert property (
    @(posedge clk) disable iff (rst)
    push |-> (occ != CAP)
  );

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (rst)
    pop |-> (occ != '0)
  );

endmodule

//--- hdl/interval_gate.sv
//------------------------------------------------------------
// Interval gate
// Valid/ready pass-through that closes for a programmed
// number of cycles after every transfer
//------------------------------------------------------------

`timescale 1ns/1ns

`include "stream_consts.svh"

module interval_gate (
  input  logic              clk,
  input  logic              rst,
  input  logic [`INTV_W-1:0] intv,
  input  logic              up_val,
  output logic              up_rdy,
  output logic              down_val,
  input  logic              down_rdy,
  output logic              fire
);

  // Remaining idle cycles
  logic [`INTV_W-1:0] cnt;
  logic               open;

  // Gate open only once the count has run out
  assign open = (cnt == '0);

  // Ready never looks at val
  assign down_val = up_val & open;
  assign up_rdy   = down_rdy & open;
  assign fire     = up_val & up_rdy;

  // Interval sampled at the transfer, then counted down
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (fire) begin
      cnt <= intv;
    end else if (!open) begin
      cnt <= cnt - 1'b1;
    end
  end

  // No transfer inside an idle window
  a_fire_when_open: assert property (
    @(posedge clk) disable iff (rst)
    fire |-> (cnt == '0)
  );

endmodule

//--- hdl/stream_pkg.sv
//------------------------------------------------------------
// Stream delay types
// Message, interval configuration and Wishbone bus structs
//------------------------------------------------------------

`include "stream_consts.svh"

package stream_pkg;

  // Stream message, tag in the upper bits
  typedef struct packed {
    logic [`TAG_W-1:0]  tag;
    logic [`DATA_W-1:0] data;
  } stream_msg_t;

  // Idle cycles after each transfer, per side
  typedef struct packed {
    logic [`INTV_W-1:0] send_intv;
    logic [`INTV_W-1:0] recv_intv;
  } delay_cfg_t;

  //----------------------------------------------------------
  // Wishbone classic, word addressed
  //----------------------------------------------------------

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat_w;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat_r;
  } wb_rsp_t;

endpackage

//--- hdl/stream_consts.svh
//------------------------------------------------------------
// Stream delay constants
// Payload and tag widths, queue depth, interval width
// and the Wishbone word addresses of the register block
//------------------------------------------------------------

`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// Message payload
`define DATA_W 32
`define TAG_W 8

// FIFO entries, power of two
`define QUEUE_DEPTH 8

// Idle-cycle interval width
`define INTV_W 8

// Register word addresses
`define REG_SEND_INTV 2'd0
`define REG_RECV_INTV 2'd1
`define REG_SEND_CNT 2'd2
`define REG_RECV_CNT 2'd3

`endif
